// ==== Makefile ====
# Verilator flow for the cache memory subsystem
TOP := memSubsysTb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check the log"
	@echo "make clean  remove the build folder and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing -j 0 --top-module $(TOP) -f all.f --Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then echo "test failed"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf obj_dir $(LOG)

// ==== all.f ====
rtl/cachePkg.sv
rtl/lineStore.sv
rtl/slowMem.sv
rtl/cacheCtrl.sv
rtl/memSubsys.sv
verif/memSubsysTb.sv

// ==== rtl/cacheCtrl.sv ====
`timescale 1ns/1ps
`default_nettype none

// direct-mapped write-through cache control
// read miss fills the whole line, writes never allocate
module cacheCtrl import cachePkg::*;
(
  input  logic                 clk,
  input  logic                 arstN,
  input  cpuReqT               cpuReq,
  output cpuRspT               cpuRsp,
  output memReqT               memReq,
  input  memRspT               memRsp,
  output logic [IdxW-1:0]      tagRdIdx,
  input  tagT                  tagRdData,
  output logic                 tagWe,
  output logic [IdxW-1:0]      tagWrIdx,
  output tagT                  tagWrData,
  output logic [IdxW+OffW-1:0] dataRdIdx,
  input  wordT                 dataRdData,
  output logic                 dataWe,
  output logic [IdxW+OffW-1:0] dataWrIdx,
  output wordT                 dataWrData
);

  typedef enum logic [2:0] {
    stIdle,
    stLookup,
    stCompare,
    stFillReq,
    stFillWait,
    stWrWait,
    stRespond
  } ctrlStateT;

  ctrlStateT state;
  ctrlStateT stateNext;

  // captured request
  logic [AddrW-1:0]    addrQ;
  wordT                wdataQ;
  logic                isWrQ;
  // read already went through a fill
  logic                missQ;
  // write hit flag, reported in respond
  logic                hitQ;
  logic [OffW-1:0]     fillCnt;
  logic [NumLines-1:0] validQ;

  tagT             addrTag;
  logic [IdxW-1:0] addrIdx;
  logic [OffW-1:0] addrOff;
  logic            lineHit;
  logic            readDone;
  logic            fillBeat;
  logic            fillLast;

  // address split: tag | index | offset | byte
  assign addrTag = addrQ[AddrW-1:AddrW-TagW];
  assign addrIdx = addrQ[IdxW+OffW+1:OffW+2];
  assign addrOff = addrQ[OffW+1:2];

  // store outputs valid in compare
  assign lineHit  = validQ[addrIdx] && (tagRdData == addrTag);
  assign readDone = (state == stCompare) && !isWrQ && lineHit;
  // one word back from memory during fill
  assign fillBeat = (state == stFillWait) && memRsp.valid;
  assign fillLast = fillBeat && (fillCnt == '1);

  always_comb
  begin
    stateNext = state;
    case (state)
      stIdle:
        if (cpuReq.re || cpuReq.we)
          stateNext = stLookup;
      // stores read at the end of lookup
      stLookup:
        stateNext = stCompare;
      stCompare:
        if (isWrQ)
          stateNext = stWrWait;
        else if (lineHit)
          stateNext = stIdle;
        else
          stateNext = stFillReq;
      // one quiet cycle between memory reads
      stFillReq:
        stateNext = stFillWait;
      stFillWait:
        if (fillLast)
          stateNext = stLookup;
        else if (fillBeat)
          stateNext = stFillReq;
      stWrWait:
        if (memRsp.valid)
          stateNext = stRespond;
      stRespond:
        stateNext = stIdle;
      default:
        stateNext = stIdle;
    endcase
  end

  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
    begin
      state   <= stIdle;
      isWrQ   <= 1'b0;
      missQ   <= 1'b0;
      hitQ    <= 1'b0;
      fillCnt <= '0;
      validQ  <= '0;
    end
    else
    begin
      state <= stateNext;
      if (state == stIdle)
      begin
        isWrQ <= cpuReq.we;
        missQ <= 1'b0;
      end
      if (state == stCompare)
        hitQ <= lineHit;
      // miss: drop the old line while it is refilled
      if (state == stCompare && !isWrQ && !lineHit)
      begin
        missQ           <= 1'b1;
        fillCnt         <= '0;
        validQ[addrIdx] <= 1'b0;
      end
      if (fillBeat)
        fillCnt <= fillCnt + 1'b1;
      if (fillLast)
        validQ[addrIdx] <= 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == stIdle)
    begin
      addrQ  <= cpuReq.addr;
      wdataQ <= cpuReq.wdata;
    end
  end

  // lookup always on the captured address
  assign tagRdIdx  = addrIdx;
  assign dataRdIdx = {addrIdx, addrOff};

  // tag written with the last fill word
  assign tagWe     = fillLast;
  assign tagWrIdx  = addrIdx;
  assign tagWrData = addrTag;

  // fill words, or the cached word on a write hit
  assign dataWe     = fillBeat || ((state == stCompare) && isWrQ && lineHit);
  assign dataWrIdx  = {addrIdx, fillBeat ? fillCnt : addrOff};
  assign dataWrData = fillBeat ? memRsp.rdata : wdataQ;

  // line reads walk the offsets, writes use the cpu address
  assign memReq.re    = (state == stFillWait);
  assign memReq.we    = (state == stWrWait);
  assign memReq.addr  = isWrQ ? addrQ : {addrTag, addrIdx, fillCnt, 2'b00};
  assign memReq.wdata = wdataQ;

  // hit reported low for a read that needed a fill
  assign cpuRsp.done  = readDone || (state == stRespond);
  assign cpuRsp.hit   = (state == stRespond) ? hitQ : (readDone && !missQ);
  assign cpuRsp.rdata = dataRdData;

endmodule

`default_nettype wire

// ==== rtl/cachePkg.sv ====
`default_nettype none

package cachePkg;

  // cpu byte address and data word
  localparam int AddrW = 32;
  localparam int DataW = 32;

  // cache geometry, direct mapped
  localparam int BlockWords = 4;
  localparam int NumLines   = 16;
  localparam int OffW       = 2;
  localparam int IdxW       = 4;
  // tag is everything above index, offset and byte bits
  localparam int TagW       = AddrW - IdxW - OffW - 2;

  // backing memory, word addressed by addr[13:2]
  localparam int MemWords   = 4096;
  localparam int WaitCycles = 3;

  typedef logic [DataW-1:0] wordT;
  typedef logic [TagW-1:0]  tagT;

  // processor side, levels held until done
  typedef struct packed {
    logic             re;
    logic             we;
    logic [AddrW-1:0] addr;
    wordT             wdata;
  } cpuReqT;

  // done is a single-cycle pulse
  typedef struct packed {
    logic done;
    logic hit;
    wordT rdata;
  } cpuRspT;

  // controller to slow memory
  typedef struct packed {
    logic             re;
    logic             we;
    logic [AddrW-1:0] addr;
    wordT             wdata;
  } memReqT;

  typedef struct packed {
    logic valid;
    wordT rdata;
  } memRspT;

endpackage

`default_nettype wire

// ==== rtl/lineStore.sv ====
`timescale 1ns/1ps
`default_nettype none

// generic storage array for cache lines
// holds tags in one instance and data words in the other
module lineStore #(
  parameter type payloadT = logic [31:0],
  parameter int  Depth    = 16
) (
  input  logic                     clk,
  // read port, data one cycle after index
  input  logic [$clog2(Depth)-1:0] rdIdx,
  output payloadT                  rdData,
  // single write port
  input  logic                     we,
  input  logic [$clog2(Depth)-1:0] wrIdx,
  input  payloadT                  wrData
);

  // contents carry no reset
  // line validity is tracked by the controller
  payloadT store [Depth];

  // write lands at the clock edge
  always_ff @(posedge clk)
  begin
    if (we)
    begin
      store[wrIdx] <= wrData;
    end
  end

  // registered read port
  // same-address read during write returns the old entry
  always_ff @(posedge clk)
  begin
    rdData <= store[rdIdx];
  end

endmodule

`default_nettype wire

// ==== rtl/memSubsys.sv ====
`timescale 1ns/1ps
`default_nettype none

// cache plus slow backing memory
module memSubsys import cachePkg::*;
(
  input  logic   clk,
  input  logic   arstN,
  input  cpuReqT cpuReq,
  output cpuRspT cpuRsp
);

  // controller to memory
  memReqT memReq;
  memRspT memRsp;

  // tag store port
  logic [IdxW-1:0] tagRdIdx;
  tagT             tagRdData;
  logic            tagWe;
  logic [IdxW-1:0] tagWrIdx;
  tagT             tagWrData;

  // data store port, index and word offset
  logic [IdxW+OffW-1:0] dataRdIdx;
  wordT                 dataRdData;
  logic                 dataWe;
  logic [IdxW+OffW-1:0] dataWrIdx;
  wordT                 dataWrData;

  cacheCtrl ctrl0 (
    .clk        (clk),
    .arstN      (arstN),
    .cpuReq     (cpuReq),
    .cpuRsp     (cpuRsp),
    .memReq     (memReq),
    .memRsp     (memRsp),
    .tagRdIdx   (tagRdIdx),
    .tagRdData  (tagRdData),
    .tagWe      (tagWe),
    .tagWrIdx   (tagWrIdx),
    .tagWrData  (tagWrData),
    .dataRdIdx  (dataRdIdx),
    .dataRdData (dataRdData),
    .dataWe     (dataWe),
    .dataWrIdx  (dataWrIdx),
    .dataWrData (dataWrData)
  );

  // one tag per line
  lineStore #(.payloadT(tagT), .Depth(NumLines)) tagStore0 (
    .clk    (clk),
    .rdIdx  (tagRdIdx),
    .rdData (tagRdData),
    .we     (tagWe),
    .wrIdx  (tagWrIdx),
    .wrData (tagWrData)
  );

  // one entry per cached word
  lineStore #(.payloadT(wordT), .Depth(NumLines * BlockWords)) dataStore0 (
    .clk    (clk),
    .rdIdx  (dataRdIdx),
    .rdData (dataRdData),
    .we     (dataWe),
    .wrIdx  (dataWrIdx),
    .wrData (dataWrData)
  );

  slowMem mem0 (
    .clk    (clk),
    .arstN  (arstN),
    .memReq (memReq),
    .memRsp (memRsp)
  );

endmodule

`default_nettype wire

// ==== rtl/slowMem.sv ====
`timescale 1ns/1ps
`default_nettype none

// word memory with fixed wait states
// answers each access with a one-cycle valid
module slowMem import cachePkg::*;
(
  input  logic   clk,
  input  logic   arstN,
  input  memReqT memReq,
  output memRspT memRsp
);

  typedef enum logic [1:0] {
    stIdle,
    stWaiting,
    stRetrieved
  } memStateT;

  // wide enough to count the wait cycles
  typedef logic [$clog2(WaitCycles+1)-1:0] cntT;

  memStateT state;
  memStateT stateNext;
  cntT      waitCnt;
  wordT     mem [MemWords];
  wordT     rdQ;
  logic [$clog2(MemWords)-1:0] wordIdx;
  logic     reqSeen;

  // word index, upper address bits alias
  assign wordIdx = memReq.addr[$clog2(MemWords)+1:2];
  assign reqSeen = memReq.re | memReq.we;

  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
      state <= stIdle;
    else
      state <= stateNext;
  end

  always_comb
  begin
    stateNext = state;
    case (state)
      stIdle:
        if (reqSeen)
          stateNext = stWaiting;
      // stay for WaitCycles cycles
      stWaiting:
        if (waitCnt == cntT'(WaitCycles - 1))
          stateNext = stRetrieved;
      stRetrieved:
        stateNext = stIdle;
      default:
        stateNext = stIdle;
    endcase
  end

  // wait counter, cleared outside the waiting state
  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
      waitCnt <= '0;
    else if (state == stWaiting)
      waitCnt <= waitCnt + 1'b1;
    else
      waitCnt <= '0;
  end

  // request sampled in idle, write stored right away
  always_ff @(posedge clk)
  begin
    if (state == stIdle && memReq.we)
      mem[wordIdx] <= memReq.wdata;
    if (state == stIdle && memReq.re)
      rdQ <= mem[wordIdx];
  end

  assign memRsp.valid = (state == stRetrieved);
  assign memRsp.rdata = rdQ;

endmodule

`default_nettype wire

// ==== verif/memSubsysTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module memSubsysTb import cachePkg::*;
();

  // 4 ns clock
  localparam int ClkHalf     = 2;
  localparam int ResetCycles = 2;
  localparam int IdleCycles  = 6;
  localparam int NumDirected = 18;
  localparam int NumRandom   = 30;
  localparam int TableLen    = NumDirected + NumRandom;
  // read hit: lookup cycle then compare cycle
  localparam int HitLatency  = 2;
  // worst case entry is a read miss, about 30 cycles
  localparam int WatchdogCycles = TableLen * 40 + 40;

  typedef enum logic {
    opRead,
    opWrite
  } opT;

  // one table row, stimulus plus expected response
  typedef struct packed {
    opT               op;
    logic [AddrW-1:0] addr;
    wordT             wdata;
    logic             expHit;
    wordT             expData;
  } entryT;

  typedef logic [$clog2(MemWords)-1:0] memIdxT;

  logic   clk;
  logic   arstN;
  cpuReqT cpuReq;
  cpuRspT cpuRsp;

  entryT stim [TableLen];

  // reference model, memory words and cache tags
  wordT                memModel [memIdxT];
  tagT                 tagModel [NumLines];
  logic [NumLines-1:0] validModel;

  integer seed;
  int     dataErrs;
  int     hitErrs;
  int     latErrs;
  int     protoErrs;
  int     n;

  memSubsys dut0 (
    .clk    (clk),
    .arstN  (arstN),
    .cpuReq (cpuReq),
    .cpuRsp (cpuRsp)
  );

  initial
  begin
    clk = 1'b0;
    forever #(ClkHalf) clk = ~clk;
  end

  function automatic string opName(input opT op);
    return (op == opRead) ? "read" : "write";
  endfunction

  task automatic setEntry(input int i, input opT op, input logic [AddrW-1:0] addr,
                          input wordT wdata);
    stim[i].op      = op;
    stim[i].addr    = addr;
    stim[i].wdata   = wdata;
    stim[i].expHit  = 1'b0;
    stim[i].expData = '0;
  endtask

  task automatic buildDirected();
    // two words of line 0x200, then the first read misses
    setEntry(0, opWrite, 32'h0000_0200, 32'hA5A5_0001);
    setEntry(1, opWrite, 32'h0000_0208, 32'h5A5A_0002);
    setEntry(2, opRead,  32'h0000_0200, '0);
    // same line, other word and same word, both hits
    setEntry(3, opRead,  32'h0000_0208, '0);
    setEntry(4, opRead,  32'h0000_0200, '0);
    // write hits on the cached line
    setEntry(5, opWrite, 32'h0000_020C, 32'hC0DE_0003);
    setEntry(6, opRead,  32'h0000_020C, '0);
    setEntry(7, opWrite, 32'h0000_0208, 32'hD00D_0004);
    setEntry(8, opRead,  32'h0000_0208, '0);
    // uncached write, no allocate
    setEntry(9,  opWrite, 32'h0000_0330, 32'hE1E1_0005);
    setEntry(10, opRead,  32'h0000_0330, '0);
    setEntry(11, opRead,  32'h0000_0330, '0);
    // index 4 shared by tags 0 and 1
    setEntry(12, opWrite, 32'h0000_0040, 32'hF00F_0006);
    setEntry(13, opWrite, 32'h0000_0140, 32'h1234_0007);
    setEntry(14, opRead,  32'h0000_0040, '0);
    setEntry(15, opRead,  32'h0000_0140, '0);
    setEntry(16, opRead,  32'h0000_0040, '0);
    setEntry(17, opRead,  32'h0000_0140, '0);
  endtask

  task automatic buildRandom();
    logic [AddrW-1:0] written [$];
    logic [AddrW-1:0] addr;
    int               i;
    int               span;
    int               pick;
    for (i = NumDirected; i < TableLen; i++)
    begin
      if (written.size() == 0 || ($random(seed) & 1) == 0)
      begin
        // word aligned, inside the 16 KB window
        addr = $random(seed) & 32'h0000_3FFC;
        setEntry(i, opWrite, addr, $random(seed));
        written.push_back(addr);
      end
      else
      begin
        // reads favour the last few writes, gives some hits
        span = (written.size() < 4) ? written.size() : 4;
        pick = written.size() - 1 - int'({$random(seed)} % span);
        setEntry(i, opRead, written[pick], '0);
      end
    end
  endtask

  // walk the table through the reference model
  task automatic computeExpected();
    logic [3:0] idx;
    tagT        tag;
    memIdxT     w;
    int         i;
    validModel = '0;
    for (i = 0; i < TableLen; i++)
    begin
      idx = stim[i].addr[7:4];
      tag = stim[i].addr[31:8];
      w   = stim[i].addr[13:2];
      stim[i].expHit = validModel[idx] && (tagModel[idx] == tag);
      if (stim[i].op == opWrite)
        memModel[w] = stim[i].wdata;
      else
      begin
        stim[i].expData = memModel.exists(w) ? memModel[w] : '0;
        // read miss fills the line
        if (!stim[i].expHit)
        begin
          validModel[idx] = 1'b1;
          tagModel[idx]   = tag;
        end
      end
    end
  endtask

  // no request raised, outputs must stay quiet
  task automatic checkIdle(input int cycles);
    int k;
    for (k = 0; k < cycles; k++)
    begin
      @(negedge clk);
      if (cpuRsp.done !== 1'b0 || cpuRsp.hit !== 1'b0)
      begin
        protoErrs++;
        $display("ERR %0t: done %b hit %b while idle", $time, cpuRsp.done, cpuRsp.hit);
      end
    end
  endtask

  task automatic runEntry(input int i);
    entryT e;
    int    cycles;
    e = stim[i];
    @(negedge clk);
    // done is a pulse, must be low again
    if (cpuRsp.done !== 1'b0)
    begin
      protoErrs++;
      $display("ERR %0t: entry %0d done high before the request", $time, i);
    end
    cpuReq.re    = (e.op == opRead);
    cpuReq.we    = (e.op == opWrite);
    cpuReq.addr  = e.addr;
    cpuReq.wdata = e.wdata;
    @(negedge clk);
    cycles = 1;
    while (cpuRsp.done !== 1'b1)
    begin
      @(negedge clk);
      cycles++;
    end
    if (cpuRsp.hit !== e.expHit)
    begin
      hitErrs++;
      $display("ERR %0t: entry %0d %s 0x%08h hit %b expected %b", $time, i,
               opName(e.op), e.addr, cpuRsp.hit, e.expHit);
    end
    if (e.op == opRead && cpuRsp.rdata !== e.expData)
    begin
      dataErrs++;
      $display("ERR %0t: entry %0d read 0x%08h rdata 0x%08h expected 0x%08h", $time, i,
               e.addr, cpuRsp.rdata, e.expData);
    end
    if (e.op == opRead && e.expHit && cycles != HitLatency)
    begin
      latErrs++;
      $display("ERR %0t: entry %0d read hit took %0d cycles expected %0d", $time, i,
               cycles, HitLatency);
    end
    // drop for one cycle before the next row
    cpuReq = '0;
  endtask

  initial
  begin
    seed      = 73883;
    cpuReq    = '0;
    arstN     = 1'b0;
    dataErrs  = 0;
    hitErrs   = 0;
    latErrs   = 0;
    protoErrs = 0;
    buildDirected();
    buildRandom();
    computeExpected();
    repeat (ResetCycles) @(negedge clk);
    arstN = 1'b1;
    checkIdle(IdleCycles);
    for (n = 0; n < TableLen; n++)
      runEntry(n);
    @(negedge clk);
    $display("errors: data %0d, hit %0d, latency %0d, protocol %0d",
             dataErrs, hitErrs, latErrs, protoErrs);
    if (dataErrs + hitErrs + latErrs + protoErrs == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

  // stops a hung handshake
  initial
  begin
    repeat (WatchdogCycles + ResetCycles + IdleCycles) @(posedge clk);
    $display("watchdog expired, the table did not finish in time");
    $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire
